/* sources.f */
+incdir+tests
design/spim_cfg_pkg.sv
design/spim_apb_decode.sv
design/spim_cfg_regs.sv
design/spim_apb_readback.sv
design/spim_apb_cfg.sv
tests/tb_spim_apb_cfg.sv

/* Bender.yml */
package:
  name: spim_apb_cfg

sources:
  - files:
      - design/spim_cfg_pkg.sv
      - design/spim_apb_decode.sv
      - design/spim_cfg_regs.sv
      - design/spim_apb_readback.sv
      - design/spim_apb_cfg.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_spim_apb_cfg.sv

/* tests/spim_cfg_model.svh */
`ifndef SPIM_CFG_MODEL_SVH
`define SPIM_CFG_MODEL_SVH

// ----------------------------------------
// expected state of the register map
// ----------------------------------------
spim_cfg_t   m_cfg;     // configuration after the last write
spim_cmd_t   m_cmd;     // pulses live in the cycle after the last write
logic [31:0] rng_state;

function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

function automatic void reset_expected();
    m_cfg            = '0;
    m_cfg.tx_fifo_wm = 5'd8;
    m_cfg.rx_fifo_wm = 5'd8;
    m_cfg.clkdiv     = 8'd1;
    m_cmd            = '0;
endfunction

function automatic void apply_write(input logic [31:0] addr, input logic [31:0] d);
    m_cmd = '0;
    if (addr[31:8] == 24'h40_0220) begin // anything outside the 256-byte window is ignored
        case (addr[7:0])
            8'h00: m_cfg.tx_data = d[7:0];
            8'h04: begin
                m_cfg.tx_fifo_wm      = d[28:24];
                m_cfg.rx_fifo_wm      = d[20:16];
                m_cmd.tx_fifo_clr     = d[11];
                m_cmd.rx_fifo_clr     = d[10];
                m_cmd.trans_logic_clr = d[8];
                m_cmd.trans_enable    = d[1];
                m_cmd.update          = d[0];
            end
            8'h08: {m_cfg.clkdiv, m_cfg.mode, m_cfg.tm, m_cfg.fm_en, m_cfg.txm,
                    m_cfg.rxm} = d[31:18];
            8'h10: begin
                {m_cfg.rx_msblsb, m_cfg.tx_msblsb} = d[19:18];
                m_cmd.pause_continue = d[17];
                m_cfg.pause_enable   = d[16];
                m_cfg.tx_num         = d[15:8];
                m_cfg.trans_num      = d[7:0];
            end
            8'h14: m_cfg.int_en = d[5:0];
            8'h18: m_cmd.int_clr = d[5:0];
            default: ;
        endcase
    end
endfunction

// live holds the pulses visible during the read, st the datapath status
function automatic logic [31:0] expected_read(input logic [31:0] addr, input spim_cmd_t live,
                                              input spim_status_t st);
    if (addr[31:8] != 24'h40_0220) return 32'h0;
    case (addr[7:0])
        8'h04: return {3'b0, m_cfg.tx_fifo_wm, 3'b0, m_cfg.rx_fifo_wm, 4'b0, live.tx_fifo_clr,
                       live.rx_fifo_clr, 1'b0, live.trans_logic_clr, 6'b0, live.trans_enable,
                       live.update};
        8'h08: return {m_cfg.clkdiv, m_cfg.mode, m_cfg.tm, m_cfg.fm_en, m_cfg.txm, m_cfg.rxm,
                       18'b0};
        8'h10: return {12'b0, m_cfg.rx_msblsb, m_cfg.tx_msblsb, live.pause_continue,
                       m_cfg.pause_enable, m_cfg.tx_num, m_cfg.trans_num};
        8'h14: return {26'b0, m_cfg.int_en};
        8'h18: return {26'b0, live.int_clr};
        8'h1c: return {19'b0, st.tx_fifo_num, 3'b0, st.rx_fifo_num};
        8'h20: return {26'b0, st.int_sta};
        8'h24: return {24'b0, st.rx_data};
        default: return 32'h0; // transmit data and the gap at 0x0c read as zero
    endcase
endfunction

`endif

/* tests/tb_spim_apb_cfg.sv */
module tb_spim_apb_cfg import spim_cfg_pkg::*; ();

    localparam int          clk_period = 8;
    localparam int          n_trans    = 900; // upper bound on APB transfers in all tests
    localparam logic [31:0] base       = 32'h4002_2000;

    logic         clk;
    logic         rst_n;
    apb_req_t     apb;
    spim_status_t status;
    logic [31:0]  prdata;
    spim_cfg_t    cfg;
    spim_cmd_t    cmd;
    logic         tx_data_wr;
    logic         rx_data_rd;
    int           checks;
    int           errors;
    int           tests;
    int           err_mark;

    `include "spim_cfg_model.svh"

    spim_apb_cfg uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb        (apb),
        .status     (status),
        .prdata     (prdata),
        .cfg        (cfg),
        .cmd        (cmd),
        .tx_data_wr (tx_data_wr),
        .rx_data_rd (rx_data_rd)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((n_trans * 3 + 400) * clk_period);
        $display("watchdog expired before all tests completed");
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ----------------------------------------
    // checks and bus tasks
    // ----------------------------------------
    task automatic compare_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp)
        else begin
            $display("[FAIL] %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s done with %0d errors", tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    // setup, access, then one idle cycle in which the pulses are live
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b1;
        apb.paddr   = addr;
        apb.pwdata  = data;
        #3;
        compare_val("tx_data_wr", 0, tx_data_wr);
        compare_val("rx_data_rd", 0, rx_data_rd); // a write setup never pops the receive FIFO
        compare_val("cmd", 0, cmd); // earlier pulses are gone by now
        @(posedge clk);
        #1;
        apb.penable = 1'b1;
        #3;
        compare_val("tx_data_wr", addr == base, tx_data_wr);
        compare_val("rx_data_rd", 0, rx_data_rd);
        compare_val("cfg", m_cfg, cfg); // nothing moves before the access ends
        @(posedge clk);
        #1;
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b0;
        apply_write(addr, data);
        #3;
        compare_val("cfg", m_cfg, cfg);
        compare_val("cmd", m_cmd, cmd);
        compare_val("prdata", expected_read(addr, m_cmd, status), prdata);
    endtask

    // leaves the bus in the access phase, the next transfer may follow directly
    task automatic read_and_compare(input logic [31:0] addr);
        @(posedge clk);
        #1;
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b0;
        apb.paddr   = addr;
        #3;
        compare_val("rx_data_rd", addr == base + 32'h24, rx_data_rd);
        compare_val("cmd", 0, cmd);
        @(posedge clk);
        #1;
        apb.penable = 1'b1;
        #3;
        compare_val("rx_data_rd", 0, rx_data_rd);
        compare_val("prdata", expected_read(addr, '0, status), prdata);
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        logic [7:0]  all_offs[10]  = '{8'h00, 8'h04, 8'h08, 8'h0c, 8'h10, 8'h14, 8'h18, 8'h1c,
                                       8'h20, 8'h24};
        logic [7:0]  rw_offs[4]    = '{8'h04, 8'h08, 8'h10, 8'h14};
        logic [7:0]  pulse_offs[3] = '{8'h04, 8'h10, 8'h18};
        logic [31:0] bad_addr[8]   = '{base + 32'h0c, base + 32'h28, base + 32'h2c,
                                       base + 32'h40, base + 32'h06, base + 32'h104,
                                       base + 32'h1014, 32'h4002_3018};
        logic [31:0] addr;
        logic [31:0] r;

        rst_n     = 1'b0;
        apb       = '0;
        status    = '0;
        checks    = 0;
        errors    = 0;
        tests     = 0;
        err_mark  = 0;
        rng_state = 32'hbc986a6f;
        reset_expected();
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        foreach (all_offs[i]) read_and_compare(base + 32'(all_offs[i]));
        compare_val("cfg", m_cfg, cfg);
        finish_test("reset values");

        repeat (300) begin
            addr = base + 32'(rw_offs[next_rand() % 4]);
            bus_write(addr, next_rand());
            read_and_compare(addr);
        end
        finish_test("random register writes");

        repeat (20) begin
            foreach (pulse_offs[i]) begin
                bus_write(base + 32'(pulse_offs[i]), next_rand());
                @(posedge clk);
                #4;
                compare_val("cmd", 0, cmd); // one cycle wide only
            end
        end
        finish_test("command pulses");

        repeat (10) begin
            bus_write(base, next_rand());
            read_and_compare(base);
        end
        finish_test("transmit data");

        repeat (20) begin
            @(posedge clk);
            #1;
            r = next_rand();
            status = spim_status_t'(r[23:0]);
            read_and_compare(base + 32'h1c);
            read_and_compare(base + 32'h20);
            read_and_compare(base + 32'h24);
        end
        bus_write(base + 32'h24, next_rand()); // a write there must not pop
        finish_test("status readback");

        repeat (20) begin
            addr = bad_addr[next_rand() % 8];
            bus_write(addr, next_rand());
            read_and_compare(addr);
        end
        compare_val("cfg", m_cfg, cfg);
        finish_test("unmapped addresses");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* design/spim_apb_cfg.sv */
module spim_apb_cfg import spim_cfg_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  apb_req_t     apb,
    input  spim_status_t status,
    output logic [31:0]  prdata,
    output spim_cfg_t    cfg,
    output spim_cmd_t    cmd,
    output logic         tx_data_wr,
    output logic         rx_data_rd
);

    reg_sel_t wr_sel;
    reg_sel_t rd_sel;

    // ----------------------------------------
    // bus decode
    // ----------------------------------------
    spim_apb_decode u_decode (
        .apb    (apb),
        .wr_sel (wr_sel),
        .rd_sel (rd_sel)
    );

    // ----------------------------------------
    // configuration and command registers
    // ----------------------------------------
    spim_cfg_regs u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_sel (wr_sel),
        .pwdata (apb.pwdata), // decoded per register through the union views
        .cfg    (cfg),
        .cmd    (cmd)
    );

    // ----------------------------------------
    // read data
    // ----------------------------------------
    spim_apb_readback u_readback (
        .paddr  (apb.paddr),
        .cfg    (cfg),
        .cmd    (cmd),
        .status (status),
        .prdata (prdata)
    );

    assign tx_data_wr = wr_sel[sel_tx_data]; // access cycle of a transmit-data write
    assign rx_data_rd = rd_sel[sel_rx_data]; // setup cycle, pops the receive FIFO

endmodule

/* design/spim_apb_readback.sv */
module spim_apb_readback import spim_cfg_pkg::*; (
    input  logic [31:0]  paddr,
    input  spim_cfg_t    cfg,
    input  spim_cmd_t    cmd,
    input  spim_status_t status,
    output logic [31:0]  prdata
);

    top_ctrl_t   top_img;
    pe_ctrl0_t   pe0_img;
    trans_ctrl_t trans_img;
    fifo_sta_t   fifo_img;

    // ----------------------------------------
    // register images, reserved bits zero
    // ----------------------------------------
    always_comb begin
        top_img                 = '0;
        top_img.tx_fifo_wm      = cfg.tx_fifo_wm;
        top_img.rx_fifo_wm      = cfg.rx_fifo_wm;
        top_img.tx_fifo_clr     = cmd.tx_fifo_clr; // clear bits show the live pulse
        top_img.rx_fifo_clr     = cmd.rx_fifo_clr;
        top_img.trans_logic_clr = cmd.trans_logic_clr;
        top_img.trans_enable    = cmd.trans_enable;
        top_img.update          = cmd.update;
    end

    always_comb begin
        pe0_img        = '0;
        pe0_img.clkdiv = cfg.clkdiv;
        pe0_img.mode   = cfg.mode;
        pe0_img.tm     = cfg.tm;
        pe0_img.fm_en  = cfg.fm_en;
        pe0_img.txm    = cfg.txm;
        pe0_img.rxm    = cfg.rxm;
    end

    always_comb begin
        trans_img                = '0;
        trans_img.rx_msblsb      = cfg.rx_msblsb;
        trans_img.tx_msblsb      = cfg.tx_msblsb;
        trans_img.pause_continue = cmd.pause_continue;
        trans_img.pause_enable   = cfg.pause_enable;
        trans_img.tx_num         = cfg.tx_num;
        trans_img.trans_num      = cfg.trans_num;
    end

    always_comb begin
        fifo_img             = '0;
        fifo_img.tx_fifo_num = status.tx_fifo_num;
        fifo_img.rx_fifo_num = status.rx_fifo_num;
    end

    // ----------------------------------------
    // read mux
    // ----------------------------------------
    always_comb begin
        case (paddr)
            cfg_base_addr + 32'(off_tx_data):    prdata = 32'h0; // write-only data port
            cfg_base_addr + 32'(off_top_ctrl):   prdata = top_img;
            cfg_base_addr + 32'(off_pe_ctrl0):   prdata = pe0_img;
            cfg_base_addr + 32'(off_trans_ctrl): prdata = trans_img;
            cfg_base_addr + 32'(off_int_en):     prdata = 32'(cfg.int_en);
            cfg_base_addr + 32'(off_int_clr):    prdata = 32'(cmd.int_clr);
            cfg_base_addr + 32'(off_fifo_sta):   prdata = fifo_img;
            cfg_base_addr + 32'(off_int_sta):    prdata = 32'(status.int_sta);
            cfg_base_addr + 32'(off_rx_data):    prdata = 32'(status.rx_data);
            default:                             prdata = 32'h0;
        endcase
    end

endmodule

/* design/spim_cfg_regs.sv */
module spim_cfg_regs import spim_cfg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_sel_t  wr_sel,
    input  cfg_word_u pwdata,
    output spim_cfg_t cfg,
    output spim_cmd_t cmd
);

    // ----------------------------------------
    // persistent configuration
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.tx_data <= 8'h0;
        end else if (wr_sel[sel_tx_data]) begin
            cfg.tx_data <= pwdata.raw[7:0]; // seen by the datapath one cycle after tx_data_wr
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.tx_fifo_wm <= wm_reset;
            cfg.rx_fifo_wm <= wm_reset;
        end else if (wr_sel[sel_top_ctrl]) begin
            cfg.tx_fifo_wm <= pwdata.top.tx_fifo_wm;
            cfg.rx_fifo_wm <= pwdata.top.rx_fifo_wm;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.clkdiv <= clkdiv_reset;
            cfg.mode   <= 2'h0;
            cfg.tm     <= 1'b0;
            cfg.fm_en  <= 1'b0;
            cfg.txm    <= 1'b0;
            cfg.rxm    <= 1'b0;
        end else if (wr_sel[sel_pe_ctrl0]) begin
            cfg.clkdiv <= pwdata.pe0.clkdiv;
            cfg.mode   <= pwdata.pe0.mode;
            cfg.tm     <= pwdata.pe0.tm;
            cfg.fm_en  <= pwdata.pe0.fm_en;
            cfg.txm    <= pwdata.pe0.txm;
            cfg.rxm    <= pwdata.pe0.rxm;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.rx_msblsb    <= 1'b0;
            cfg.tx_msblsb    <= 1'b0;
            cfg.pause_enable <= 1'b0;
            cfg.tx_num       <= 8'h0;
            cfg.trans_num    <= 8'h0;
        end else if (wr_sel[sel_trans_ctrl]) begin
            cfg.rx_msblsb    <= pwdata.trans.rx_msblsb;
            cfg.tx_msblsb    <= pwdata.trans.tx_msblsb;
            cfg.pause_enable <= pwdata.trans.pause_enable;
            cfg.tx_num       <= pwdata.trans.tx_num;
            cfg.trans_num    <= pwdata.trans.trans_num;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.int_en <= '0;
        end else if (wr_sel[sel_int_en]) begin
            cfg.int_en <= pwdata.raw[int_num-1:0];
        end
    end

    // ----------------------------------------
    // command pulses
    // ----------------------------------------
    // a pulse follows its write bit for one cycle and drops on any other cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd <= '0;
        end else begin
            cmd <= '0;
            if (wr_sel[sel_top_ctrl]) begin
                cmd.tx_fifo_clr     <= pwdata.top.tx_fifo_clr;
                cmd.rx_fifo_clr     <= pwdata.top.rx_fifo_clr;
                cmd.trans_logic_clr <= pwdata.top.trans_logic_clr;
                cmd.trans_enable    <= pwdata.top.trans_enable;
                cmd.update          <= pwdata.top.update;
            end
            if (wr_sel[sel_trans_ctrl]) begin
                cmd.pause_continue <= pwdata.trans.pause_continue;
            end
            if (wr_sel[sel_int_clr]) begin
                cmd.int_clr <= pwdata.raw[int_num-1:0];
            end
        end
    end

    // back-to-back writes still cannot stretch a pulse, since the APB access
    // phase of one write is never followed directly by the access phase of the next
    assert property (@(posedge clk) disable iff (!rst_n) ~|(cmd & $past(cmd)))
        else $error("command pulse held for two cycles");

endmodule

/* design/spim_apb_decode.sv */
module spim_apb_decode import spim_cfg_pkg::*; (
    input  apb_req_t apb,
    output reg_sel_t wr_sel,
    output reg_sel_t rd_sel
);

    logic     wr_phase;
    logic     rd_phase;
    reg_sel_t addr_hit;

    // ----------------------------------------
    // phase qualification
    // ----------------------------------------
    assign wr_phase = apb.psel & apb.penable & apb.pwrite; // access phase of a write
    assign rd_phase = apb.psel & ~apb.penable & ~apb.pwrite; // setup phase of a read

    // ----------------------------------------
    // address match
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < reg_num; i++) begin
            addr_hit[i] = (apb.paddr == cfg_base_addr + 32'(reg_off[i]));
        end
    end

    assign wr_sel = wr_phase ? addr_hit : '0;
    assign rd_sel = rd_phase ? addr_hit : '0;

    // each value is checked when the bus next changes, so a stable select is seen once
    assert property (@(apb) $onehot0(wr_sel) && $onehot0(rd_sel))
        else $error("register select is not one-hot");

endmodule

/* design/spim_cfg_pkg.sv */
package spim_cfg_pkg;

    // ----------------------------------------
    // address map
    // ----------------------------------------
    localparam logic [31:0] cfg_base_addr = 32'h4002_2000;

    localparam logic [7:0] off_tx_data    = 8'h00;
    localparam logic [7:0] off_top_ctrl   = 8'h04;
    localparam logic [7:0] off_pe_ctrl0   = 8'h08;
    localparam logic [7:0] off_trans_ctrl = 8'h10; // 0x0c is left unmapped
    localparam logic [7:0] off_int_en     = 8'h14;
    localparam logic [7:0] off_int_clr    = 8'h18;
    localparam logic [7:0] off_fifo_sta   = 8'h1c;
    localparam logic [7:0] off_int_sta    = 8'h20;
    localparam logic [7:0] off_rx_data    = 8'h24;

    localparam int fifo_lvl_w = 5;
    localparam int int_num    = 6;

    typedef logic [fifo_lvl_w-1:0] fifo_lvl_t;
    typedef logic [int_num-1:0]    int_vec_t;

    localparam fifo_lvl_t  wm_reset     = 5'd8;
    localparam logic [7:0] clkdiv_reset = 8'd1;

    // one select bit per kept register, in address order
    typedef enum int unsigned {
        sel_tx_data,
        sel_top_ctrl,
        sel_pe_ctrl0,
        sel_trans_ctrl,
        sel_int_en,
        sel_int_clr,
        sel_fifo_sta,
        sel_int_sta,
        sel_rx_data
    } reg_idx_e;

    localparam int reg_num = 9;

    typedef logic [reg_num-1:0] reg_sel_t;

    localparam logic [7:0] reg_off [reg_num] = '{
        off_tx_data, off_top_ctrl, off_pe_ctrl0, off_trans_ctrl, off_int_en,
        off_int_clr, off_fifo_sta, off_int_sta, off_rx_data
    };

    // ----------------------------------------
    // register layouts
    // ----------------------------------------
    typedef struct packed {
        logic [2:0] rsvd_31;
        fifo_lvl_t  tx_fifo_wm;
        logic [2:0] rsvd_23;
        fifo_lvl_t  rx_fifo_wm;
        logic [3:0] rsvd_15;
        logic       tx_fifo_clr;
        logic       rx_fifo_clr;
        logic       rsvd_9;
        logic       trans_logic_clr;
        logic [5:0] rsvd_7;
        logic       trans_enable;
        logic       update;
    } top_ctrl_t;

    typedef struct packed {
        logic [7:0]  clkdiv;
        logic [1:0]  mode;
        logic        tm;
        logic        fm_en;
        logic        txm;
        logic        rxm;
        logic [17:0] rsvd_17;
    } pe_ctrl0_t;

    typedef struct packed {
        logic [11:0] rsvd_31;
        logic        rx_msblsb;
        logic        tx_msblsb;
        logic        pause_continue; // command pulse, not stored
        logic        pause_enable;
        logic [7:0]  tx_num;
        logic [7:0]  trans_num;
    } trans_ctrl_t;

    typedef struct packed {
        logic [18:0] rsvd_31;
        fifo_lvl_t   tx_fifo_num;
        logic [2:0]  rsvd_7;
        fifo_lvl_t   rx_fifo_num;
    } fifo_sta_t;

    // the same write word seen through each register layout
    typedef union packed {
        logic [31:0] raw;
        top_ctrl_t   top;
        pe_ctrl0_t   pe0;
        trans_ctrl_t trans;
    } cfg_word_u;

    // ----------------------------------------
    // bundles at the block boundary
    // ----------------------------------------
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [7:0] tx_data;
        fifo_lvl_t  tx_fifo_wm;
        fifo_lvl_t  rx_fifo_wm;
        logic [7:0] clkdiv;
        logic [1:0] mode;
        logic       tm;
        logic       fm_en;
        logic       txm;
        logic       rxm;
        logic       rx_msblsb;
        logic       tx_msblsb;
        logic       pause_enable;
        logic [7:0] tx_num;
        logic [7:0] trans_num;
        int_vec_t   int_en;
    } spim_cfg_t;

    typedef struct packed {
        logic     tx_fifo_clr;
        logic     rx_fifo_clr;
        logic     trans_logic_clr;
        logic     trans_enable;
        logic     update;
        logic     pause_continue;
        int_vec_t int_clr;
    } spim_cmd_t;

    typedef struct packed {
        fifo_lvl_t  tx_fifo_num;
        fifo_lvl_t  rx_fifo_num;
        int_vec_t   int_sta;
        logic [7:0] rx_data;
    } spim_status_t;

endpackage
